/* Makefile */
# Verilator simulation of the AXI4-Lite loopback buffer

VERILATOR ?= verilator
TOP       ?= tb_axi_axis_loopback
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Regression passed

.PHONY: sim clean

# the log search decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* axi_bridge/axi_axis_reader.sv */
`timescale 1ns/1ps

module axi_axis_reader
(
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic                                    s_axi_arvalid,
  output logic                                    s_axi_arready,
  output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output axi_lite_pkg::axi_resp_t                 s_axi_rresp,
  output logic                                    s_axi_rvalid,
  input  logic                                    s_axi_rready,
  input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] s_axis_tdata,
  input  logic                                    s_axis_tvalid,
  output logic                                    s_axis_tready
);
  import axi_lite_pkg::*;

  logic                      rvalid_reg, rvalid_next;
  logic                      captured_reg, captured_next;
  logic [AXI_DATA_WIDTH-1:0] rdata_reg, rdata_next;

  always @(posedge aclk)
  begin
    if (~aresetn)
    begin
      rvalid_reg   <= 1'b0;
      captured_reg <= 1'b0;
    end
    else
    begin
      rvalid_reg   <= rvalid_next;
      captured_reg <= captured_next;
    end
  end

  always @(posedge aclk)
  begin
    rdata_reg <= rdata_next;
  end

  always @*
  begin
    rvalid_next   = rvalid_reg;
    captured_next = captured_reg;
    rdata_next    = rdata_reg;
    if (s_axi_arvalid)
    begin
      rvalid_next   = 1'b1;
      captured_next = s_axis_tvalid;  // empty read takes nothing
      rdata_next    = s_axis_tvalid ? s_axis_tdata : '0;
    end
    if (s_axi_rready & rvalid_reg)
      rvalid_next = 1'b0;
  end

  assign s_axi_arready = 1'b1;
  assign s_axi_rdata   = rdata_reg;
  assign s_axi_rvalid  = rvalid_reg;
  assign s_axi_rresp   = RESP_OKAY;

  // pop only a word that was really handed out
  assign s_axis_tready = s_axi_rready & rvalid_reg & captured_reg;

endmodule

/* axi_bridge/axi_axis_writer.sv */
`timescale 1ns/1ps

module axi_axis_writer
(
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  logic                                    s_axi_awvalid,
  output logic                                    s_axi_awready,
  input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] s_axi_wdata,
  input  logic                                    s_axi_wvalid,
  output logic                                    s_axi_wready,
  output axi_lite_pkg::axi_resp_t                 s_axi_bresp,
  output logic                                    s_axi_bvalid,
  input  logic                                    s_axi_bready,
  output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] m_axis_tdata,
  output logic                                    m_axis_tvalid,
  input  logic                                    m_axis_tready
);
  import axi_lite_pkg::*;

  writer_state_t             state_reg, state_next;
  logic [AXI_DATA_WIDTH-1:0] data_reg;
  logic                      accept;

  // address and data are taken together, only when idle
  assign accept = (state_reg == WR_IDLE) & s_axi_awvalid & s_axi_wvalid;

  always @(posedge aclk)
  begin
    if (~aresetn)
      state_reg <= WR_IDLE;
    else
      state_reg <= state_next;
  end

  always @(posedge aclk)
  begin
    if (accept)
      data_reg <= s_axi_wdata;  // held until the push
  end

  always @*
  begin
    state_next = state_reg;
    case (state_reg)
      WR_IDLE:
      begin
        if (accept)
          state_next = WR_PUSH;
      end
      WR_PUSH:
      begin
        // stays here while the fifo is full
        if (m_axis_tready)
          state_next = WR_RESP;
      end
      WR_RESP:
      begin
        if (s_axi_bready)
          state_next = WR_IDLE;
      end
      default:
      begin
        state_next = WR_IDLE;
      end
    endcase
  end

  assign s_axi_awready = accept;
  assign s_axi_wready  = accept;

  assign m_axis_tdata  = data_reg;
  assign m_axis_tvalid = (state_reg == WR_PUSH);

  assign s_axi_bvalid  = (state_reg == WR_RESP);
  assign s_axi_bresp   = RESP_OKAY;  // no error cases

endmodule

/* common/axi_lite_pkg.sv */
package axi_lite_pkg;

  // one 32-bit word per transfer
  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_ADDR_WIDTH = 16;  // one register window

  // standard AXI response encodings
  typedef enum logic [1:0]
  {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

  // write side: accept aw/w, push to stream, answer on b
  typedef enum logic [1:0]
  {
    WR_IDLE = 2'd0,
    WR_PUSH = 2'd1,
    WR_RESP = 2'd2
  } writer_state_t;

endpackage

/* common/stream_fifo_pkg.sv */
package stream_fifo_pkg;

  localparam int FIFO_DEPTH       = 16;  // words
  localparam int FIFO_PTR_WIDTH   = 4;   // wraps at depth
  localparam int FIFO_COUNT_WIDTH = 5;   // 0 .. FIFO_DEPTH

endpackage

/* flist.f */
common/axi_lite_pkg.sv
common/stream_fifo_pkg.sv
axi_bridge/axi_axis_writer.sv
axi_bridge/axi_axis_reader.sv
verilog/axis_fifo.sv
verilog/axi_axis_loopback.sv
verification/tb_axi_axis_loopback.sv

/* verification/tb_axi_axis_loopback.sv */
`timescale 1ns/1ps

module tb_axi_axis_loopback;
  import axi_lite_pkg::*;
  import stream_fifo_pkg::*;

  localparam int CLK_HALF      = 50;  // 100 ns period
  localparam int RESET_CYCLES  = 3;
  localparam int CYCLES_PER_OP = 40;
  localparam int WAIT_LIMIT    = 64;  // cycles for one handshake
  localparam int STALL_CYCLES  = 10;
  localparam int RANDOM_OPS    = 40;

  localparam int OP_WRITE       = 0;
  localparam int OP_READ        = 1;
  localparam int OP_WRITE_STALL = 2;  // write into a full fifo, no b handshake yet
  localparam int OP_WAIT_B      = 3;
  localparam int OP_READ_OPEN   = 4;  // ar only, r handshake left pending
  localparam int OP_READ_CLOSE  = 5;

  logic                      aclk;
  logic                      aresetn;
  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr;
  logic                      s_axi_awvalid;
  logic                      s_axi_awready;
  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata;
  logic                      s_axi_wvalid;
  logic                      s_axi_wready;
  axi_resp_t                 s_axi_bresp;
  logic                      s_axi_bvalid;
  logic                      s_axi_bready;
  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr;
  logic                      s_axi_arvalid;
  logic                      s_axi_arready;
  logic [AXI_DATA_WIDTH-1:0] s_axi_rdata;
  axi_resp_t                 s_axi_rresp;
  logic                      s_axi_rvalid;
  logic                      s_axi_rready;

  // test table, one entry per operation
  int                        op_q[$];
  logic [AXI_DATA_WIDTH-1:0] data_q[$];  // write data or expected read data
  int                        dly_q[$];
  string                     name_q[$];

  logic [AXI_DATA_WIDTH-1:0] model_q[$];  // scoreboard copy of the fifo
  logic [31:0]               rng;
  int                        table_len;
  logic [AXI_DATA_WIDTH-1:0] open_rdata;  // read data of the pending read

  axi_axis_loopback u_dut
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
  );

  always #CLK_HALF aclk = ~aclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      abort_run($sformatf("Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual));
  endtask

  task automatic add_op(input int op, input logic [31:0] data, input int dly,
                        input string name);
    op_q.push_back(op);
    data_q.push_back(data);
    dly_q.push_back(dly);
    name_q.push_back(name);
  endtask

  task automatic add_write(input logic [31:0] data, input int dly, input string name);
    model_q.push_back(data);
    add_op(OP_WRITE, data, dly, name);
  endtask

  task automatic add_read_op(input int op, input int dly, input string name);
    logic [31:0] expected;
    expected = '0;  // empty fifo reads as zero
    if (model_q.size() != 0)
      expected = model_q.pop_front();
    add_op(op, expected, dly, name);
  endtask

  task automatic add_read(input int dly, input string name);
    add_read_op(OP_READ, dly, name);
  endtask

  task automatic build_table();
    int dly;
    // the write lands while the empty read still waits for rready
    add_read_op(OP_READ_OPEN, 0, "empty_read");
    add_write(32'hcafe_0001, 0, "empty_read");
    add_op(OP_READ_CLOSE, '0, 1, "empty_read");
    add_read(1, "empty_read");
    for (int k = 0; k < 5; k++)
      add_write(32'h1000_0000 + k, 0, "ordering");
    for (int k = 0; k < 5; k++)
      add_read(0, "ordering");
    for (int k = 0; k < FIFO_DEPTH; k++)
    begin
      rng = xorshift32(rng);
      add_write(rng, 0, "full");
    end
    rng = xorshift32(rng);
    model_q.push_back(rng);
    add_op(OP_WRITE_STALL, rng, 0, "full");
    add_read(0, "full");  // frees one slot for the stalled write
    add_op(OP_WAIT_B, '0, 0, "full");
    for (int k = 0; k < FIFO_DEPTH; k++)
      add_read(0, "full");
    for (int k = 0; k < RANDOM_OPS; k++)
    begin
      rng = xorshift32(rng);
      dly = int'(rng[5:4]);
      if (rng[0] && model_q.size() < FIFO_DEPTH)
      begin
        rng = xorshift32(rng);
        add_write(rng, dly, "random");
      end
      else
        add_read(dly, "random");
    end
    table_len = op_q.size();
  endtask

  task automatic to_drive_point();
    @(posedge aclk);
    #1;
  endtask

  task automatic to_sample_point();
    @(negedge aclk);  // mid cycle, outputs settled
  endtask

  task automatic accept_write(input logic [31:0] data, input string name);
    int n;
    n = 0;
    to_drive_point();
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wvalid  = 1'b1;
    to_sample_point();
    while (!s_axi_awready)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_run($sformatf("%s: write address was never accepted", name));
      to_sample_point();
    end
    check_value({name, " wready"}, 32'd1, 32'(s_axi_wready));
    to_drive_point();
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
  endtask

  task automatic finish_bresp(input int dly, input string name);
    int n;
    n = 0;
    to_sample_point();
    while (!s_axi_bvalid)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_run($sformatf("%s: write response never arrived", name));
      to_sample_point();
    end
    check_value({name, " bresp"}, 32'(RESP_OKAY), 32'(s_axi_bresp));
    repeat (dly)
    begin
      to_drive_point();
      to_sample_point();
      check_value({name, " bvalid held"}, 32'd1, 32'(s_axi_bvalid));
    end
    to_drive_point();
    s_axi_bready = 1'b1;
    to_sample_point();
    check_value({name, " bvalid"}, 32'd1, 32'(s_axi_bvalid));
    to_drive_point();
    s_axi_bready = 1'b0;
  endtask

  task automatic start_read(input logic [31:0] expected, input string name,
                            output logic [31:0] first);
    to_drive_point();
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b1;
    to_sample_point();
    check_value({name, " arready"}, 32'd1, 32'(s_axi_arready));
    check_value({name, " rvalid early"}, 32'd0, 32'(s_axi_rvalid));
    to_drive_point();
    s_axi_arvalid = 1'b0;
    to_sample_point();
    check_value({name, " rvalid"}, 32'd1, 32'(s_axi_rvalid));  // one cycle after ar
    check_value({name, " rresp"}, 32'(RESP_OKAY), 32'(s_axi_rresp));
    check_value({name, " rdata"}, expected, s_axi_rdata);
    first = s_axi_rdata;
  endtask

  task automatic end_read(input logic [31:0] first, input int dly, input string name);
    repeat (dly)
    begin
      to_drive_point();
      to_sample_point();
      check_value({name, " rvalid held"}, 32'd1, 32'(s_axi_rvalid));
      check_value({name, " rdata held"}, first, s_axi_rdata);
    end
    to_drive_point();
    s_axi_rready = 1'b1;
    to_sample_point();
    check_value({name, " rdata at handshake"}, first, s_axi_rdata);
    to_drive_point();
    s_axi_rready = 1'b0;
    to_sample_point();
    check_value({name, " rvalid after"}, 32'd0, 32'(s_axi_rvalid));
  endtask

  task automatic do_read(input logic [31:0] expected, input int dly, input string name);
    logic [31:0] first;
    start_read(expected, name, first);
    end_read(first, dly, name);
  endtask

  initial
  begin
    string tname;
    aclk          = 1'b0;
    aresetn       = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    table_len     = 0;
    open_rdata    = '0;
    rng           = 32'd82107;
    build_table();
    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    to_sample_point();
    check_value("reset bvalid", 32'd0, 32'(s_axi_bvalid));
    check_value("reset rvalid", 32'd0, 32'(s_axi_rvalid));
    check_value("reset awready", 32'd0, 32'(s_axi_awready));
    check_value("reset wready", 32'd0, 32'(s_axi_wready));
    for (int i = 0; i < table_len; i++)
    begin
      tname = $sformatf("%s #%0d", name_q[i], i);
      case (op_q[i])
        OP_WRITE:
        begin
          accept_write(data_q[i], tname);
          finish_bresp(dly_q[i], tname);
        end
        OP_WRITE_STALL:
        begin
          accept_write(data_q[i], tname);
          repeat (STALL_CYCLES)
          begin
            to_sample_point();
            check_value({tname, " bvalid while full"}, 32'd0, 32'(s_axi_bvalid));
          end
        end
        OP_WAIT_B:
          finish_bresp(dly_q[i], tname);
        OP_READ_OPEN:
          start_read(data_q[i], tname, open_rdata);
        OP_READ_CLOSE:
          end_read(open_rdata, dly_q[i], tname);
        default:
          do_read(data_q[i], dly_q[i], tname);
      endcase
    end
    $display("Regression passed");
    $finish;
  end

  // watchdog
  initial
  begin
    wait (table_len > 0);
    repeat (RESET_CYCLES + table_len * CYCLES_PER_OP) @(posedge aclk);
    abort_run("timeout: the tests did not finish in the expected number of cycles");
  end

endmodule

/* verilog/axi_axis_loopback.sv */
`timescale 1ns/1ps

module axi_axis_loopback
(
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  logic                                    s_axi_awvalid,
  output logic                                    s_axi_awready,
  input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] s_axi_wdata,
  input  logic                                    s_axi_wvalid,
  output logic                                    s_axi_wready,
  output axi_lite_pkg::axi_resp_t                 s_axi_bresp,
  output logic                                    s_axi_bvalid,
  input  logic                                    s_axi_bready,
  input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic                                    s_axi_arvalid,
  output logic                                    s_axi_arready,
  output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output axi_lite_pkg::axi_resp_t                 s_axi_rresp,
  output logic                                    s_axi_rvalid,
  input  logic                                    s_axi_rready
);
  import axi_lite_pkg::*;

  // writer to fifo
  logic [AXI_DATA_WIDTH-1:0] wr_tdata;
  logic                      wr_tvalid;
  logic                      wr_tready;

  // fifo to reader
  logic [AXI_DATA_WIDTH-1:0] rd_tdata;
  logic                      rd_tvalid;
  logic                      rd_tready;

  axi_axis_writer u_writer
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .m_axis_tdata  (wr_tdata),
    .m_axis_tvalid (wr_tvalid),
    .m_axis_tready (wr_tready)
  );

  axis_fifo u_fifo
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (wr_tdata),
    .s_axis_tvalid (wr_tvalid),
    .s_axis_tready (wr_tready),
    .m_axis_tdata  (rd_tdata),
    .m_axis_tvalid (rd_tvalid),
    .m_axis_tready (rd_tready)
  );

  axi_axis_reader u_reader
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .s_axis_tdata  (rd_tdata),
    .s_axis_tvalid (rd_tvalid),
    .s_axis_tready (rd_tready)
  );

endmodule

/* verilog/axis_fifo.sv */
`timescale 1ns/1ps

module axis_fifo
(
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] s_axis_tdata,
  input  logic                                    s_axis_tvalid,
  output logic                                    s_axis_tready,
  output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] m_axis_tdata,
  output logic                                    m_axis_tvalid,
  input  logic                                    m_axis_tready
);
  import axi_lite_pkg::*;
  import stream_fifo_pkg::*;

  logic [AXI_DATA_WIDTH-1:0]   mem [FIFO_DEPTH];
  logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
  logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
  logic [FIFO_COUNT_WIDTH-1:0] count;
  logic                        push;
  logic                        pop;

  assign push = s_axis_tvalid & s_axis_tready;
  assign pop  = m_axis_tvalid & m_axis_tready;

  always @(posedge aclk)
  begin
    if (push)
      mem[wr_ptr] <= s_axis_tdata;
  end

  // pointers wrap on their own, depth is a power of two
  always @(posedge aclk)
  begin
    if (~aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always @(posedge aclk)
  begin
    if (~aresetn)
      count <= '0;
    else
    begin
      case ({push, pop})
        2'b10:
          count <= count + 1'b1;
        2'b01:
          count <= count - 1'b1;
        default:
          count <= count;  // none, or one in and one out
      endcase
    end
  end

  // all flags from registered state, head word always on the output
  assign s_axis_tready = (count != FIFO_COUNT_WIDTH'(FIFO_DEPTH));
  assign m_axis_tvalid = (count != '0);
  assign m_axis_tdata  = mem[rd_ptr];

endmodule
